// ==== logic_analyzer_top.f ====
design/la_cfg_pkg.sv
design/la_data_pkg.sv
design/capture_if.sv
design/sample_rate_gen.sv
design/trigger_capture_ctrl.sv
design/capture_ram.sv
design/readout_seq.sv
design/logic_analyzer_top.sv
tb/tb_logic_analyzer_asserts.sv
tb/tb_logic_analyzer.sv

// ==== tb/la_input_cases.txt ====
// columns (hex): mode chan pre_num div_value pattern_start stall_percent
// first word is the number of cases, mode codes 5 to 7 are undefined
14
0 0 04 0 10 00
1 1 08 1 00 19
2 2 05 0 33 1e
3 3 0a 2 7a 14
4 0 00 0 fe 28
2 4 10 1 c0 0a
3 5 03 0 05 32
0 2 1f 0 40 14
1 0 00 3 00 00
4 3 14 0 e8 3c
5 0 07 0 20 14
7 6 0c 1 99 23
2 1 01 5 01 0f
2 2 05 4 33 1e
3 0 00 0 f0 46
1 7 02 0 80 19
0 5 06 2 1f 2d
6 3 1f 0 00 0a
4 5 09 1 3c 19
2 0 1e 0 55 28

// ==== tb/tb_logic_analyzer.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_logic_analyzer;

  localparam int ADDR_W = 5;
  localparam int DEPTH  = 2**ADDR_W;
  localparam int NCOL   = 6;

  logic                   iSysClk = 1'b0;
  logic                   arst_n;
  logic                   arm;
  la_cfg_pkg::div_t       div_value;
  la_cfg_pkg::trig_mode_e trig_mode;
  la_cfg_pkg::chan_sel_t  chan_sel;
  la_cfg_pkg::pre_cnt_t   pre_num;
  la_data_pkg::sample_t   chan_in = '0;
  logic                   out_ready = 1'b0;
  logic                   capture_done;
  la_data_pkg::sample_t   out_data;
  logic                   out_valid;
  logic                   out_last;

  // word 0 is the case count, NCOL words per case follow
  logic [15:0]          case_mem [0:NCOL*64];
  la_data_pkg::sample_t got_q[$];
  bit                   last_q[$];
  bit                   stream_end;
  bit                   pat_on;
  logic [7:0]           pat_start = '0;
  int                   pat_phase;
  int                   done_cnt;
  int                   stall_pct;
  int                   cycles = 0;
  int                   cycle_limit = 0;
  int                   err_cnt = 0;

  always #4 iSysClk = ~iSysClk;

  logic_analyzer_top #(.ADDR_W(ADDR_W)) dut0 (.*);

  // pattern steps every div_value+1 cycles counted from the arm edge
  always @(posedge iSysClk) begin
    out_ready <= ($urandom % 100) >= stall_pct;
    if (!pat_on) begin
      chan_in   <= pat_start;
      pat_phase <= 0;
    end else if (pat_phase == div_value) begin
      chan_in   <= chan_in + 1'b1;
      pat_phase <= 0;
    end else begin
      pat_phase <= pat_phase + 1;
    end
  end

  // collect every transfer on the output port
  always @(posedge iSysClk) begin
    if (capture_done)
      done_cnt = done_cnt + 1;
    if (out_valid && out_ready) begin
      got_q.push_back(out_data);
      last_q.push_back(out_last);
      if (out_last)
        stream_end = 1'b1;
    end
  end

  always @(posedge iSysClk)
    cycles <= cycles + 1;

  initial begin
    wait (cycle_limit > 0);
    wait (cycles >= cycle_limit);
    $display("timeout: run did not finish within %0d clock cycles", cycle_limit);
    $display("sim failed");
    $finish;
  end

  // sample k sees the pattern after k+1 steps
  function automatic logic [7:0] pattern_word(input logic [7:0] start, input int k);
    int w;
    w = start + k + 1;
    return w[7:0];
  endfunction

  function automatic int first_trigger(input int mode, input int ch, input int pre,
                                       input logic [7:0] start);
    int         k;
    logic [7:0] cur;
    logic [7:0] prv;
    bit         hit;
    for (k = pre; k < pre + 512; k++) begin
      cur = pattern_word(start, k);
      prv = pattern_word(start, k - 1);
      case (mode)
        0: hit = !cur[ch];
        1: hit = cur[ch];
        // edges need a previous sample
        2: hit = k > 0 && cur[ch] && !prv[ch];
        3: hit = k > 0 && !cur[ch] && prv[ch];
        4: hit = k > 0 && cur[ch] != prv[ch];
        default: hit = 1'b1;
      endcase
      if (hit)
        return k;
    end
    return -1;
  endfunction

  task automatic run_case(input int idx, output bit ok);
    int                   mode;
    int                   ch;
    int                   pre;
    int                   start;
    int                   trig;
    int                   errs0;
    int                   i;
    la_data_pkg::sample_t exp_w;
    mode  = case_mem[1 + idx*NCOL];
    ch    = case_mem[2 + idx*NCOL];
    pre   = case_mem[3 + idx*NCOL];
    start = case_mem[5 + idx*NCOL];
    errs0 = err_cnt;
    // configure while disarmed
    @(posedge iSysClk);
    trig_mode  <= la_cfg_pkg::trig_mode_e'(mode[2:0]);
    chan_sel   <= ch[2:0];
    pre_num    <= pre[9:0];
    div_value  <= case_mem[4 + idx*NCOL];
    pat_start  = start[7:0];
    stall_pct  = case_mem[6 + idx*NCOL];
    stream_end = 1'b0;
    done_cnt   = 0;
    got_q.delete();
    last_q.delete();
    @(posedge iSysClk);
    arm    <= 1'b1;
    pat_on <= 1'b1;
    wait (stream_end);
    @(posedge iSysClk);
    arm    <= 1'b0;
    pat_on <= 1'b0;
    trig = first_trigger(mode, ch, pre, start[7:0]);
    assert (done_cnt == 1) else begin
      $display("ERR %0t: case %0d saw %0d capture_done pulses", $time, idx, done_cnt);
      err_cnt++;
    end
    assert (got_q.size() == DEPTH) else begin
      $display("ERR %0t: case %0d read %0d words, expected %0d", $time, idx, got_q.size(),
               DEPTH);
      err_cnt++;
    end
    for (i = 0; i < got_q.size(); i++) begin
      exp_w = pattern_word(start[7:0], trig - pre + i);
      assert (got_q[i] == exp_w) else begin
        $display("ERR %0t: case %0d word %0d is %h, expected %h", $time, idx, i, got_q[i],
                 exp_w);
        err_cnt++;
      end
      assert (i == 0 || got_q[i] == got_q[i-1] + 8'd1) else begin
        $display("ERR %0t: case %0d word %0d does not follow the previous word", $time,
                 idx, i);
        err_cnt++;
      end
      assert (last_q[i] == (i == DEPTH - 1)) else begin
        $display("ERR %0t: case %0d out_last is %0b on word %0d", $time, idx, last_q[i], i);
        err_cnt++;
      end
    end
    ok = (err_cnt == errs0);
    $display("case %0d: mode %0d chan %0d pre %0d div %0d, trigger at sample %0d, %0d words, %s",
             idx, mode, ch, pre, case_mem[4 + idx*NCOL], trig, got_q.size(),
             ok ? "ok" : "FAILED");
  endtask

  initial begin
    int n_cases;
    int n_pass;
    int c;
    int budget;
    bit ok;
    void'($urandom(32'hb8c1));
    arst_n    = 1'b0;
    arm       = 1'b0;
    div_value = '0;
    trig_mode = la_cfg_pkg::MODE_LOW;
    chan_sel  = '0;
    pre_num   = '0;
    n_pass    = 0;
    $readmemh("tb/la_input_cases.txt", case_mem);
    n_cases = case_mem[0];
    if (n_cases == 0)
      $display("no test cases could be read from tb/la_input_cases.txt");
    // capture up to 4*depth samples, readout up to 8 cycles a word
    budget = 1000;
    for (c = 0; c < n_cases; c++)
      budget += DEPTH * 4 * (case_mem[4 + c*NCOL] + 1) + DEPTH * 8;
    cycle_limit = budget;
    repeat (3) @(posedge iSysClk);
    arst_n <= 1'b1;
    for (c = 0; c < n_cases; c++) begin
      run_case(c, ok);
      if (ok)
        n_pass++;
    end
    $display("%0d cases, %0d passed, %0d failed, %0d check errors, %0d assertion failures",
             n_cases, n_pass, n_cases - n_pass, err_cnt, dut0.u_asserts.fail_cnt);
    if (n_cases > 0 && err_cnt == 0 && dut0.u_asserts.fail_cnt == 0)
      $display("sim passed");
    else
      $display("sim failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb/tb_logic_analyzer_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_logic_analyzer_asserts (
  input wire logic                 iSysClk,
  input wire logic                 arst_n,
  input wire logic                 capture_done,
  input wire la_data_pkg::sample_t out_data,
  input wire logic                 out_valid,
  input wire logic                 out_ready,
  input wire logic                 out_last
);

  int fail_cnt = 0;

  // stalled word stays on the port
  a_hold: assert property (@(posedge iSysClk) disable iff (!arst_n)
    (out_valid && !out_ready) |=> (out_valid && $stable(out_data)))
  else begin
    $error("out_data or out_valid changed while the word was stalled");
    fail_cnt++;
  end

  a_done: assert property (@(posedge iSysClk) disable iff (!arst_n)
    capture_done |=> !capture_done)
  else begin
    $error("capture_done stayed high for more than one cycle");
    fail_cnt++;
  end

  a_last: assert property (@(posedge iSysClk) disable iff (!arst_n)
    out_last |-> out_valid)
  else begin
    $error("out_last seen without out_valid");
    fail_cnt++;
  end

endmodule

bind logic_analyzer_top tb_logic_analyzer_asserts u_asserts (
  .iSysClk      (iSysClk),
  .arst_n       (arst_n),
  .capture_done (capture_done),
  .out_data     (out_data),
  .out_valid    (out_valid),
  .out_ready    (out_ready),
  .out_last     (out_last)
);

`default_nettype wire

// ==== design/logic_analyzer_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module logic_analyzer_top #(
  parameter int CHN_NUM = 8,
  parameter int ADDR_W  = 10
) (
  input  wire logic                   iSysClk,
  input  wire logic                   arst_n,
  input  wire logic                   arm,
  input  wire la_cfg_pkg::div_t       div_value,
  input  wire la_cfg_pkg::trig_mode_e trig_mode,
  input  wire la_cfg_pkg::chan_sel_t  chan_sel,
  input  wire la_cfg_pkg::pre_cnt_t   pre_num,
  input  wire la_data_pkg::sample_t   chan_in,
  output logic                        capture_done,
  output la_data_pkg::sample_t        out_data,
  output logic                        out_valid,
  output logic                        out_last,
  input  wire logic                   out_ready
);

  logic                 sample_tick;
  logic                 rd_en;
  la_data_pkg::addr_t   rd_addr;
  la_data_pkg::sample_t rd_data;

  capture_if cap_bus ();

  sample_rate_gen u_rate (
    .iSysClk     (iSysClk),
    .arst_n      (arst_n),
    .arm         (arm),
    .div_value   (div_value),
    .sample_tick (sample_tick)
  );

  trigger_capture_ctrl #(
    .CHN_NUM (CHN_NUM),
    .ADDR_W  (ADDR_W)
  ) u_ctrl (
    .iSysClk     (iSysClk),
    .arst_n      (arst_n),
    .arm         (arm),
    .sample_tick (sample_tick),
    .trig_mode   (trig_mode),
    .chan_sel    (chan_sel),
    .pre_num     (pre_num),
    .chan_in     (chan_in),
    .cap         (cap_bus.ctrl)
  );

  capture_ram #(
    .CHN_NUM (CHN_NUM),
    .ADDR_W  (ADDR_W)
  ) u_ram (
    .iSysClk (iSysClk),
    .mem     (cap_bus.mem),
    .rd_en   (rd_en),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

  readout_seq #(
    .CHN_NUM (CHN_NUM),
    .ADDR_W  (ADDR_W)
  ) u_rdout (
    .iSysClk   (iSysClk),
    .arst_n    (arst_n),
    .cap       (cap_bus.rd),
    .rd_en     (rd_en),
    .rd_addr   (rd_addr),
    .rd_data   (rd_data),
    .out_data  (out_data),
    .out_valid (out_valid),
    .out_last  (out_last),
    .out_ready (out_ready)
  );

  assign capture_done = cap_bus.capture_done;

endmodule

`default_nettype wire

// ==== design/readout_seq.sv ====
`timescale 1ns/1ps
`default_nettype none

module readout_seq #(
  parameter int CHN_NUM = 8,
  parameter int ADDR_W  = 10
) (
  input  wire logic                 iSysClk,
  input  wire logic                 arst_n,
  capture_if.rd                     cap,
  output logic                      rd_en,
  output la_data_pkg::addr_t        rd_addr,
  input  wire la_data_pkg::sample_t rd_data,
  output la_data_pkg::sample_t      out_data,
  output logic                      out_valid,
  output logic                      out_last,
  input  wire logic                 out_ready
);

  localparam la_data_pkg::addr_t ADDR_MASK = la_data_pkg::addr_t'(2**ADDR_W - 1);
  localparam la_data_pkg::addr_t LAST_WORD = la_data_pkg::addr_t'(2**ADDR_W - 1);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_FETCH,
    ST_HOLD
  } state_e;

  state_e             state_q;
  la_data_pkg::addr_t addr_q;
  la_data_pkg::addr_t word_cnt;
  logic               rd_pend;
  logic               valid_q;
  logic               last_q;
  logic [CHN_NUM-1:0] data_q;

  always_ff @(posedge iSysClk or negedge arst_n) begin
    if (!arst_n) begin
      state_q  <= ST_IDLE;
      addr_q   <= '0;
      word_cnt <= '0;
      rd_pend  <= 1'b0;
      valid_q  <= 1'b0;
      last_q   <= 1'b0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (cap.capture_done) begin
            addr_q   <= cap.start_addr;
            word_cnt <= '0;
            state_q  <= ST_FETCH;
          end
        end
        ST_FETCH: begin
          // read issued this cycle
          rd_pend <= 1'b1;
          state_q <= ST_HOLD;
        end
        ST_HOLD: begin
          if (rd_pend) begin
            rd_pend <= 1'b0;
            valid_q <= 1'b1;
            last_q  <= (word_cnt == LAST_WORD);
          end else if (valid_q && out_ready) begin
            valid_q <= 1'b0;
            last_q  <= 1'b0;
            if (last_q) begin
              state_q <= ST_IDLE;
            end else begin
              addr_q   <= (addr_q + 1'b1) & ADDR_MASK;
              word_cnt <= word_cnt + 1'b1;
              state_q  <= ST_FETCH;
            end
          end
        end
        default: begin
          state_q <= ST_IDLE;
        end
      endcase
    end
  end

  // output word, held until the transfer
  always_ff @(posedge iSysClk) begin
    if (state_q == ST_HOLD && rd_pend)
      data_q <= rd_data[CHN_NUM-1:0];
  end

  assign rd_en     = (state_q == ST_FETCH);
  assign rd_addr   = addr_q;
  assign out_data  = la_data_pkg::sample_t'(data_q);
  assign out_valid = valid_q;
  assign out_last  = last_q;

endmodule

`default_nettype wire

// ==== design/capture_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module capture_ram #(
  parameter int CHN_NUM = 8,
  parameter int ADDR_W  = 10
) (
  input  wire logic                 iSysClk,
  capture_if.mem                    mem,
  input  wire logic                 rd_en,
  input  wire la_data_pkg::addr_t   rd_addr,
  output la_data_pkg::sample_t      rd_data
);

  localparam int DEPTH = 2**ADDR_W;

  logic [CHN_NUM-1:0] mem_q [DEPTH];

  // write side, one word per capture strobe
  always_ff @(posedge iSysClk) begin
    if (mem.wr_en)
      mem_q[mem.wr_addr[ADDR_W-1:0]] <= mem.wr_data[CHN_NUM-1:0];
  end

  // registered read, data one cycle after rd_en
  always_ff @(posedge iSysClk) begin
    if (rd_en)
      rd_data <= la_data_pkg::sample_t'(mem_q[rd_addr[ADDR_W-1:0]]);
  end

endmodule

`default_nettype wire

// ==== design/trigger_capture_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module trigger_capture_ctrl #(
  parameter int CHN_NUM = 8,
  parameter int ADDR_W  = 10
) (
  input  wire logic                   iSysClk,
  input  wire logic                   arst_n,
  input  wire logic                   arm,
  input  wire logic                   sample_tick,
  input  wire la_cfg_pkg::trig_mode_e trig_mode,
  input  wire la_cfg_pkg::chan_sel_t  chan_sel,
  input  wire la_cfg_pkg::pre_cnt_t   pre_num,
  input  wire la_data_pkg::sample_t   chan_in,
  capture_if.ctrl                     cap
);

  localparam la_data_pkg::addr_t   ADDR_MASK = la_data_pkg::addr_t'(2**ADDR_W - 1);
  localparam la_cfg_pkg::pre_cnt_t LAST_IDX  = la_cfg_pkg::pre_cnt_t'(2**ADDR_W - 1);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_PREFILL,
    ST_WAIT_TRIG,
    ST_POST,
    ST_DONE
  } state_e;

  state_e               state_q;
  state_e               state_d;
  la_data_pkg::sample_t sample_q;
  la_data_pkg::sample_t prev_q;
  logic                 have_prev;
  logic                 wr_en_q;
  la_data_pkg::addr_t   wr_addr_q;
  la_data_pkg::addr_t   addr_next;
  la_cfg_pkg::pre_cnt_t smp_cnt;
  la_cfg_pkg::pre_cnt_t post_len;
  logic                 done_q;
  la_data_pkg::addr_t   start_q;
  logic                 writing_d;
  logic                 trig_hit;
  logic [CHN_NUM-1:0]   cur_v;
  logic [CHN_NUM-1:0]   edge_mask;
  logic [CHN_NUM-1:0]   rise_v;
  logic [CHN_NUM-1:0]   fall_v;
  logic [CHN_NUM-1:0]   any_v;
  logic [CHN_NUM-1:0]   trig_v;

  // sampled stream, prev_q is the word from the previous strobe
  always_ff @(posedge iSysClk) begin
    if (sample_tick) begin
      sample_q <= chan_in;
      prev_q   <= sample_q;
    end
  end

  // no edge on the very first written sample
  assign cur_v     = sample_q[CHN_NUM-1:0];
  assign edge_mask = {CHN_NUM{have_prev}};
  assign rise_v    = cur_v & ~prev_q[CHN_NUM-1:0] & edge_mask;
  assign fall_v    = ~cur_v & prev_q[CHN_NUM-1:0] & edge_mask;
  assign any_v     = (cur_v ^ prev_q[CHN_NUM-1:0]) & edge_mask;

  always_comb begin
    case (trig_mode)
      la_cfg_pkg::MODE_LOW:  trig_v = ~cur_v;
      la_cfg_pkg::MODE_HIGH: trig_v = cur_v;
      la_cfg_pkg::MODE_RISE: trig_v = rise_v;
      la_cfg_pkg::MODE_FALL: trig_v = fall_v;
      la_cfg_pkg::MODE_ANY:  trig_v = any_v;
      default:               trig_v = '1;
    endcase
  end

  assign trig_hit  = trig_v[chan_sel];
  assign post_len  = LAST_IDX - pre_num;
  assign addr_next = (wr_addr_q + 1'b1) & ADDR_MASK;

  always_comb begin
    state_d = state_q;
    if (!arm) begin
      state_d = ST_IDLE;
    end else begin
      case (state_q)
        ST_IDLE: begin
          state_d = (pre_num == '0) ? ST_WAIT_TRIG : ST_PREFILL;
        end
        ST_PREFILL: begin
          if (wr_en_q && (smp_cnt + 1'b1 == pre_num))
            state_d = ST_WAIT_TRIG;
        end
        ST_WAIT_TRIG: begin
          // trigger sample is written now, post_len more follow
          if (wr_en_q && trig_hit)
            state_d = (post_len == '0) ? ST_DONE : ST_POST;
        end
        ST_POST: begin
          if (wr_en_q && smp_cnt == la_cfg_pkg::pre_cnt_t'(1))
            state_d = ST_DONE;
        end
        default: begin
          state_d = state_q;
        end
      endcase
    end
  end

  // a strobe only becomes a write if the next state still captures
  assign writing_d = state_d inside {ST_PREFILL, ST_WAIT_TRIG, ST_POST};

  always_ff @(posedge iSysClk or negedge arst_n) begin
    if (!arst_n) begin
      state_q   <= ST_IDLE;
      wr_en_q   <= 1'b0;
      wr_addr_q <= '0;
      smp_cnt   <= '0;
      have_prev <= 1'b0;
      done_q    <= 1'b0;
      start_q   <= '0;
    end else begin
      state_q <= state_d;
      wr_en_q <= sample_tick & writing_d;
      done_q  <= (state_d == ST_DONE) && (state_q != ST_DONE);
      if (state_q == ST_IDLE) begin
        wr_addr_q <= '0;
        smp_cnt   <= '0;
        have_prev <= 1'b0;
      end else if (wr_en_q) begin
        wr_addr_q <= addr_next;
        have_prev <= 1'b1;
        if (state_q == ST_PREFILL)
          smp_cnt <= smp_cnt + 1'b1;
        else if (state_q == ST_WAIT_TRIG && trig_hit)
          smp_cnt <= post_len;
        else if (state_q == ST_POST)
          smp_cnt <= smp_cnt - 1'b1;
      end
      // oldest sample is the slot after the final write
      if (state_d == ST_DONE && state_q != ST_DONE)
        start_q <= addr_next;
    end
  end

  assign cap.wr_en        = wr_en_q;
  assign cap.wr_addr      = wr_addr_q;
  assign cap.wr_data      = sample_q;
  assign cap.capture_done = done_q;
  assign cap.start_addr   = start_q;

endmodule

`default_nettype wire

// ==== design/sample_rate_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module sample_rate_gen (
  input  wire logic              iSysClk,
  input  wire logic              arst_n,
  input  wire logic              arm,
  input  wire la_cfg_pkg::div_t  div_value,
  output logic                   sample_tick
);

  la_cfg_pkg::div_t cnt_q;
  logic             tick_q;

  // down-counter, reloads from div_value at zero
  // held at div_value while disarmed so the first strobe
  // comes div_value+1 cycles after arm rises
  always_ff @(posedge iSysClk or negedge arst_n) begin
    if (!arst_n) begin
      cnt_q  <= '0;
      tick_q <= 1'b0;
    end else if (!arm) begin
      cnt_q  <= div_value;
      tick_q <= 1'b0;
    end else if (cnt_q == '0) begin
      cnt_q  <= div_value;
      tick_q <= 1'b1;
    end else begin
      cnt_q  <= cnt_q - 1'b1;
      tick_q <= 1'b0;
    end
  end

  assign sample_tick = tick_q;

endmodule

`default_nettype wire

// ==== design/capture_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface capture_if;

  // memory write port
  logic                 wr_en;
  la_data_pkg::addr_t   wr_addr;
  la_data_pkg::sample_t wr_data;

  // end of capture, start_addr points at the oldest sample
  logic                 capture_done;
  la_data_pkg::addr_t   start_addr;

  modport ctrl (
    output wr_en,
    output wr_addr,
    output wr_data,
    output capture_done,
    output start_addr
  );

  modport mem (
    input wr_en,
    input wr_addr,
    input wr_data
  );

  modport rd (
    input capture_done,
    input start_addr
  );

endinterface

`default_nettype wire

// ==== design/la_data_pkg.sv ====
`default_nettype none

package la_data_pkg;

  // one word of channel levels, width must equal CHN_NUM
  typedef logic [7:0] sample_t;

  // capture buffer address, only the low ADDR_W bits are used
  typedef logic [9:0] addr_t;

endpackage

`default_nettype wire

// ==== design/la_cfg_pkg.sv ====
`default_nettype none

package la_cfg_pkg;

  // trigger condition on the monitored channel
  // codes above MODE_ANY fire on the first eligible sample
  typedef enum logic [2:0] {
    MODE_LOW  = 3'd0,
    MODE_HIGH = 3'd1,
    MODE_RISE = 3'd2,
    MODE_FALL = 3'd3,
    MODE_ANY  = 3'd4
  } trig_mode_e;

  // index of the channel that is watched for the trigger
  typedef logic [2:0] chan_sel_t;

  // sample period is div_value+1 clock cycles
  typedef logic [15:0] div_t;

  // number of samples kept ahead of the trigger sample
  typedef logic [9:0] pre_cnt_t;

endpackage

`default_nettype wire
